/* hw/sd_spi_pkg.sv */
package sd_spi_pkg;

    // ------------------------------------------------------------
    // SPI and UART timing
    // ------------------------------------------------------------
    // CLOCK_50 cycles per SPI_SCLK half period, about 400 kHz
    localparam logic [7:0] spi_half_period   = 8'd63;
    // 115200 baud from 50 MHz
    localparam logic [8:0] uart_clks_per_bit = 9'd434;

    // ------------------------------------------------------------
    // SD card bring-up
    // ------------------------------------------------------------
    // 10 bytes of 0xFF give the 80 dummy clocks
    localparam logic [3:0] dummy_bytes   = 4'd10;
    // CMD0 with its fixed CRC
    localparam logic [0:5][7:0] cmd0_bytes = {8'h40, 8'h00, 8'h00, 8'h00, 8'h00, 8'h95};
    localparam logic [7:0] idle_response = 8'h01;
    localparam logic [4:0] poll_limit    = 5'd16;

    // ------------------------------------------------------------
    // status messages
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        msg_sd,
        msg_cmd0,
        msg_ok,
        msg_to
    } msg_id_t;

    localparam int msg_chars = 5;

    // text ends at the first zero byte, or after msg_chars characters
    localparam logic [0:3][0:msg_chars-1][7:0] msg_text = {
        {"SD", 8'h0A, 16'h0000},
        {"CMD0", 8'h0A},
        {"OK", 8'h0A, 16'h0000},
        {"TO", 8'h0A, 16'h0000}
    };

endpackage

/* hw/spi_clock_divider.sv */
`timescale 1ns/1ps

module spi_clock_divider (
    input  logic CLOCK_50,
    input  logic KEY0,
    output logic sclk,
    output logic sclk_rise,
    output logic sclk_fall
);
    import sd_spi_pkg::*;

    logic [7:0] div_cnt;
    logic       half_done;

    // last cycle of the current half period
    assign half_done = (div_cnt == spi_half_period - 8'd1);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            div_cnt   <= '0;
            sclk      <= 1'b0;
            sclk_rise <= 1'b0;
            sclk_fall <= 1'b0;
        end else begin
            // ticks are high in the cycle where sclk itself changes
            sclk_rise <= half_done && !sclk;
            sclk_fall <= half_done && sclk;
            if (half_done) begin
                div_cnt <= '0;
                sclk    <= ~sclk;
            end else begin
                div_cnt <= div_cnt + 8'd1;
            end
        end
    end

endmodule

/* hw/spi_byte_shifter.sv */
`timescale 1ns/1ps

module spi_byte_shifter (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       sclk_rise,
    input  logic       sclk_fall,
    input  logic       start,
    input  logic [7:0] tx_byte,
    input  logic       miso,
    output logic       mosi,
    output logic       busy,
    output logic       done,
    output logic [7:0] rx_byte
);

    logic [7:0] tx_sr;
    logic [7:0] rx_sr;
    logic [2:0] bit_cnt;
    // set until the first falling edge has put bit 7 on mosi
    logic       lead_in;

    assign rx_byte = rx_sr;

    // ------------------------------------------------------------
    // payload shift registers
    // ------------------------------------------------------------
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            tx_sr <= 8'hFF;
            rx_sr <= 8'h00;
        end else begin
            if (start && !busy) begin
                tx_sr <= tx_byte;
            end else if (busy && !lead_in && sclk_fall) begin
                tx_sr <= {tx_sr[6:0], 1'b1};
            end
            if (busy && !lead_in && sclk_rise) begin
                rx_sr <= {rx_sr[6:0], miso};
            end
        end
    end

    // ------------------------------------------------------------
    // transfer control, mode 0
    // ------------------------------------------------------------
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            lead_in <= 1'b0;
            bit_cnt <= 3'd0;
            mosi    <= 1'b1;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy    <= 1'b1;
                    lead_in <= 1'b1;
                    bit_cnt <= 3'd0;
                end
            end else if (lead_in) begin
                if (sclk_fall) begin
                    lead_in <= 1'b0;
                    mosi    <= tx_sr[7];
                end
            end else if (sclk_rise) begin
                // the card samples here, so do we
                if (bit_cnt == 3'd7) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    mosi <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 3'd1;
                end
            end else if (sclk_fall) begin
                mosi <= tx_sr[6];
            end
        end
    end

endmodule

/* hw/sd_cmd0_sequencer.sv */
`timescale 1ns/1ps

module sd_cmd0_sequencer (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  logic                busy,
    input  logic                done,
    input  logic [7:0]          rx_byte,
    output logic                start,
    output logic [7:0]          tx_byte,
    output logic                ss_n,
    output logic                led,
    output logic                event_valid,
    output sd_spi_pkg::msg_id_t event_id
);
    import sd_spi_pkg::*;

    typedef enum logic [1:0] {
        st_dummy,
        st_command,
        st_poll,
        st_finished
    } state_t;

    state_t     state;
    logic [4:0] byte_cnt;
    // a new byte is due as soon as the shifter is free
    logic       need_start;

    // 0xFF while clocking dummies and while polling
    assign tx_byte = (state == st_command) ? cmd0_bytes[byte_cnt[2:0]] : 8'hFF;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state       <= st_dummy;
            byte_cnt    <= 5'd0;
            need_start  <= 1'b1;
            start       <= 1'b0;
            ss_n        <= 1'b1;
            led         <= 1'b0;
            event_valid <= 1'b0;
            event_id    <= msg_sd;
        end else begin
            start       <= 1'b0;
            event_valid <= 1'b0;

            if (need_start && !busy) begin
                start      <= 1'b1;
                need_start <= 1'b0;
                // first dummy byte announces the bring-up
                if (state == st_dummy && byte_cnt == 5'd0) begin
                    event_valid <= 1'b1;
                    event_id    <= msg_sd;
                end
            end

            if (done) begin
                case (state)
                    st_dummy: begin
                        need_start <= 1'b1;
                        if (byte_cnt == 5'(dummy_bytes) - 5'd1) begin
                            state    <= st_command;
                            byte_cnt <= 5'd0;
                            ss_n     <= 1'b0;
                        end else begin
                            byte_cnt <= byte_cnt + 5'd1;
                        end
                    end
                    st_command: begin
                        need_start <= 1'b1;
                        if (byte_cnt == 5'd5) begin
                            state       <= st_poll;
                            byte_cnt    <= 5'd0;
                            event_valid <= 1'b1;
                            event_id    <= msg_cmd0;
                        end else begin
                            byte_cnt <= byte_cnt + 5'd1;
                        end
                    end
                    st_poll: begin
                        if (rx_byte == idle_response) begin
                            state       <= st_finished;
                            ss_n        <= 1'b1;
                            led         <= 1'b1;
                            event_valid <= 1'b1;
                            event_id    <= msg_ok;
                        end else if (byte_cnt == poll_limit - 5'd1) begin
                            // card never answered
                            state       <= st_finished;
                            ss_n        <= 1'b1;
                            event_valid <= 1'b1;
                            event_id    <= msg_to;
                        end else begin
                            byte_cnt   <= byte_cnt + 5'd1;
                            need_start <= 1'b1;
                        end
                    end
                    default: begin
                        state <= st_finished;
                    end
                endcase
            end
        end
    end

endmodule

/* hw/status_message_tx.sv */
`timescale 1ns/1ps

module status_message_tx (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  logic                event_valid,
    input  sd_spi_pkg::msg_id_t event_id,
    output logic                txd
);
    import sd_spi_pkg::*;

    logic [3:0] pending;
    logic       active;
    msg_id_t    cur_id;
    msg_id_t    next_id;
    logic [2:0] char_idx;
    logic [3:0] bit_idx;
    logic [8:0] baud_cnt;
    // stop bit, data LSB first, start bit; shifted out from bit 0
    logic [9:0] frame;

    assign txd = frame[0];

    // lowest pending message goes first
    always_comb begin
        next_id = msg_sd;
        for (int i = 3; i >= 0; i--) begin
            if (pending[i]) begin
                next_id = msg_id_t'(i);
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pending  <= 4'b0000;
            active   <= 1'b0;
            cur_id   <= msg_sd;
            char_idx <= 3'd0;
            bit_idx  <= 4'd0;
            baud_cnt <= 9'd0;
            frame    <= '1;
        end else begin
            if (!active) begin
                if (pending != 4'b0000) begin
                    active           <= 1'b1;
                    cur_id           <= next_id;
                    char_idx         <= 3'd0;
                    bit_idx          <= 4'd0;
                    baud_cnt         <= 9'd0;
                    frame            <= {1'b1, msg_text[next_id][0], 1'b0};
                    pending[next_id] <= 1'b0;
                end
            end else if (baud_cnt == uart_clks_per_bit - 9'd1) begin
                baud_cnt <= 9'd0;
                if (bit_idx == 4'd9) begin
                    // stop bit done, move to the next character
                    bit_idx <= 4'd0;
                    if (char_idx == 3'(msg_chars - 1)) begin
                        active <= 1'b0;
                    end else if (msg_text[cur_id][char_idx + 3'd1] == 8'h00) begin
                        active <= 1'b0;
                    end else begin
                        char_idx <= char_idx + 3'd1;
                        frame    <= {1'b1, msg_text[cur_id][char_idx + 3'd1], 1'b0};
                    end
                end else begin
                    bit_idx <= bit_idx + 4'd1;
                    frame   <= {1'b1, frame[9:1]};
                end
            end else begin
                baud_cnt <= baud_cnt + 9'd1;
            end

            // new events are never dropped
            if (event_valid) begin
                pending[event_id] <= 1'b1;
            end
        end
    end

endmodule

/* hw/sd_probe_top.sv */
`timescale 1ns/1ps

module sd_probe_top (
    input  logic CLOCK_50,
    input  logic KEY0,
    input  logic SPI_MISO,
    output logic SPI_SCLK,
    output logic SPI_MOSI,
    output logic SPI_SS_n,
    output logic LEDR0,
    output logic UART_TXD
);
    import sd_spi_pkg::*;

    logic       sclk_rise;
    logic       sclk_fall;
    logic       start;
    logic       busy;
    logic       done;
    logic [7:0] tx_byte;
    logic [7:0] rx_byte;
    logic       event_valid;
    msg_id_t    event_id;

    // ------------------------------------------------------------
    // SPI side
    // ------------------------------------------------------------
    spi_clock_divider u_clk_div (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .sclk      (SPI_SCLK),
        .sclk_rise (sclk_rise),
        .sclk_fall (sclk_fall)
    );

    spi_byte_shifter u_shifter (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .sclk_rise (sclk_rise),
        .sclk_fall (sclk_fall),
        .start     (start),
        .tx_byte   (tx_byte),
        .miso      (SPI_MISO),
        .mosi      (SPI_MOSI),
        .busy      (busy),
        .done      (done),
        .rx_byte   (rx_byte)
    );

    sd_cmd0_sequencer u_seq (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .busy        (busy),
        .done        (done),
        .rx_byte     (rx_byte),
        .start       (start),
        .tx_byte     (tx_byte),
        .ss_n        (SPI_SS_n),
        .led         (LEDR0),
        .event_valid (event_valid),
        .event_id    (event_id)
    );

    // ------------------------------------------------------------
    // status trace
    // ------------------------------------------------------------
    status_message_tx u_msg_tx (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .event_valid (event_valid),
        .event_id    (event_id),
        .txd         (UART_TXD)
    );

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    initial begin
        rst_n = 1'b1;
        #1 rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* dv/sd_card_model.sv */
`timescale 1ns/1ps

module sd_card_model (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sclk,
    input  logic       mosi,
    input  logic       ss_n,
    input  logic       silent,
    input  logic [2:0] delay_bytes,
    output logic       miso,
    output logic       cmd_match
);
    import sd_spi_pkg::*;

    logic       sclk_prev;
    logic       cmd_err;
    logic [7:0] rx_sr;
    logic [7:0] out_byte;
    int         bit_cnt;
    int         byte_cnt;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_prev <= 1'b0;
            cmd_err   <= 1'b0;
            cmd_match <= 1'b0;
            rx_sr     <= 8'h00;
            out_byte  <= 8'hFF;
            miso      <= 1'b1;
            bit_cnt   <= 0;
            byte_cnt  <= 0;
        end else begin
            sclk_prev <= sclk;
            if (ss_n) begin
                // deselected: idle line, restart byte framing
                bit_cnt  <= 0;
                byte_cnt <= 0;
                out_byte <= 8'hFF;
                miso     <= 1'b1;
            end else if (sclk && !sclk_prev) begin
                rx_sr <= {rx_sr[6:0], mosi};
                if (bit_cnt == 7) begin
                    bit_cnt  <= 0;
                    byte_cnt <= byte_cnt + 1;
                    if (byte_cnt < 6) begin
                        if ({rx_sr[6:0], mosi} != cmd0_bytes[byte_cnt]) begin
                            cmd_err <= 1'b1;
                        end else if (byte_cnt == 5 && !cmd_err) begin
                            cmd_match <= 1'b1;
                        end
                    end
                    // load the byte that goes out next
                    if (!silent && byte_cnt >= 5 && byte_cnt - 5 == int'(delay_bytes)) begin
                        out_byte <= idle_response;
                    end else begin
                        out_byte <= 8'hFF;
                    end
                end else begin
                    bit_cnt <= bit_cnt + 1;
                end
            end else if (!sclk && sclk_prev) begin
                // mode 0: change data on the falling edge
                miso <= out_byte[7 - bit_cnt];
            end
        end
    end

endmodule

/* dv/tb_sd_probe.sv */
`timescale 1ns/1ps

module tb_sd_probe;
    import sd_spi_pkg::*;

    localparam int run_cycles = (int'(dummy_bytes) + 6 + int'(poll_limit)) * 126 * 2 * 8
                                + 11 * 10 * int'(uart_clks_per_bit);
    localparam int num_runs   = 4;

    logic       clk;
    logic       gen_rst_n;
    logic       key_pulse;
    logic       key0;
    logic       key0_prev;
    logic       silent;
    logic [2:0] delay_bytes;
    logic       spi_miso;
    logic       spi_sclk;
    logic       spi_mosi;
    logic       spi_ss_n;
    logic       ledr0;
    logic       uart_txd;
    logic       cmd_match;

    // SPI monitor state
    logic       sclk_prev;
    logic       ss_prev;
    logic       ss_low_seen;
    logic       run_end;
    int         dummy_rises;
    int         low_bits;

    byte unsigned rx_chars[$];
    logic [7:0]   lfsr;
    int           text_base;
    int           err_reset;
    int           err_spi;
    int           err_prop;
    int           err_run;
    int           err_uart;

    assign key0 = gen_rst_n & key_pulse;

    tb_clock_gen i_clk_gen (
        .clk   (clk),
        .rst_n (gen_rst_n)
    );

    sd_probe_top i_dut (
        .CLOCK_50 (clk),
        .KEY0     (key0),
        .SPI_MISO (spi_miso),
        .SPI_SCLK (spi_sclk),
        .SPI_MOSI (spi_mosi),
        .SPI_SS_n (spi_ss_n),
        .LEDR0    (ledr0),
        .UART_TXD (uart_txd)
    );

    sd_card_model i_card (
        .clk         (clk),
        .rst_n       (key0),
        .sclk        (spi_sclk),
        .mosi        (spi_mosi),
        .ss_n        (spi_ss_n),
        .silent      (silent),
        .delay_bytes (delay_bytes),
        .miso        (spi_miso),
        .cmd_match   (cmd_match)
    );

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic string msg_string(input int id);
        string s;
        logic  ended;
        s     = "";
        ended = 1'b0;
        for (int k = 0; k < msg_chars; k++) begin
            if (msg_text[id][k] == 8'h00) begin
                ended = 1'b1;
            end
            if (!ended) begin
                s = $sformatf("%s%c", s, msg_text[id][k]);
            end
        end
        return s;
    endfunction

    // ----------------------------------------------------------
    // checkers
    // ----------------------------------------------------------
    // outputs at reset values while KEY0 is low and one cycle after
    always @(posedge clk) begin
        key0_prev <= key0;
        if (!key0 || !key0_prev) begin
            assert (spi_ss_n === 1'b1) else begin
                err_reset++;
                $display("error %0t SPI_SS_n expected 1 got %b", $time, spi_ss_n);
            end
            assert (spi_mosi === 1'b1) else begin
                err_reset++;
                $display("error %0t SPI_MOSI expected 1 got %b", $time, spi_mosi);
            end
            assert (spi_sclk === 1'b0) else begin
                err_reset++;
                $display("error %0t SPI_SCLK expected 0 got %b", $time, spi_sclk);
            end
            assert (ledr0 === 1'b0) else begin
                err_reset++;
                $display("error %0t LEDR0 expected 0 got %b", $time, ledr0);
            end
            assert (uart_txd === 1'b1) else begin
                err_reset++;
                $display("error %0t UART_TXD expected 1 got %b", $time, uart_txd);
            end
        end
    end

    // a silent card never lights the LED
    assert property (@(posedge clk) disable iff (!key0) silent |-> !ledr0)
    else begin
        err_prop++;
        $display("error %0t LEDR0 expected 0 got %b", $time, ledr0);
    end

    always @(posedge clk) begin
        if (!key0) begin
            sclk_prev   <= 1'b0;
            ss_prev     <= 1'b1;
            ss_low_seen <= 1'b0;
            run_end     <= 1'b0;
            dummy_rises <= 0;
            low_bits    <= 0;
        end else begin
            sclk_prev <= spi_sclk;
            ss_prev   <= spi_ss_n;
            if (spi_sclk && !sclk_prev) begin
                if (!ss_low_seen && spi_ss_n && spi_mosi) begin
                    dummy_rises <= dummy_rises + 1;
                end
                if (!spi_ss_n) begin
                    if (low_bits < 48) begin
                        assert (spi_mosi === cmd0_bytes[low_bits / 8][7 - low_bits % 8])
                        else begin
                            err_spi++;
                            $display("error %0t SPI_MOSI bit %0d expected %b got %b", $time,
                                     low_bits, cmd0_bytes[low_bits / 8][7 - low_bits % 8],
                                     spi_mosi);
                        end
                    end
                    low_bits <= low_bits + 1;
                end
            end
            if (!spi_ss_n && ss_prev && !ss_low_seen) begin
                ss_low_seen <= 1'b1;
                assert (dummy_rises >= 80) else begin
                    err_spi++;
                    $display("only %0d dummy clocks before chip select fell", dummy_rises);
                end
            end
            if (spi_ss_n && !ss_prev && ss_low_seen) begin
                run_end <= 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // UART decoder, 8N1
    // ----------------------------------------------------------
    // stops waiting as soon as reset cuts the character
    task automatic wait_bit_time(input int n, inout logic aborted);
        repeat (n) begin
            if (!aborted) begin
                @(posedge clk);
                if (!key0) begin
                    aborted = 1'b1;
                end
            end
        end
    endtask

    initial begin
        logic [7:0] ch;
        logic       aborted;
        forever begin
            @(posedge clk);
            if (key0 && uart_txd === 1'b0) begin
                aborted = 1'b0;
                wait_bit_time(int'(uart_clks_per_bit) / 2, aborted);
                for (int b = 0; b < 8; b++) begin
                    wait_bit_time(int'(uart_clks_per_bit), aborted);
                    ch[b] = uart_txd;
                end
                wait_bit_time(int'(uart_clks_per_bit), aborted);
                // a character cut by reset is dropped
                if (!aborted) begin
                    assert (uart_txd === 1'b1) else begin
                        err_uart++;
                        $display("error %0t UART_TXD stop bit expected 1 got %b", $time,
                                 uart_txd);
                    end
                    rx_chars.push_back(ch);
                end
            end
        end
    end

    // ----------------------------------------------------------
    // run control
    // ----------------------------------------------------------
    task automatic start_run(input logic be_silent, output int d);
        logic [2:0] draw;
        draw = 3'd0;
        for (int b = 0; b < 3; b++) begin
            lfsr = lfsr_next(lfsr);
            draw = {draw[1:0], lfsr[0]};
        end
        d = int'(draw);
        @(posedge clk);
        key_pulse   <= 1'b0;
        silent      <= be_silent;
        delay_bytes <= draw;
        repeat (8) @(posedge clk);
        key_pulse <= 1'b1;
        @(posedge clk);
        text_base = rx_chars.size();
    endtask

    task automatic finish_run(input logic expect_ok, input int d);
        string exp;
        int    poll_bytes;
        while (!run_end) @(posedge clk);
        poll_bytes = (low_bits - 48) / 8;
        exp = {msg_string(int'(msg_sd)), msg_string(int'(msg_cmd0)),
               msg_string(expect_ok ? int'(msg_ok) : int'(msg_to))};
        if (expect_ok) begin
            assert (ledr0 === 1'b1) else begin
                err_run++;
                $display("error %0t LEDR0 expected 1 got %b", $time, ledr0);
            end
            assert (poll_bytes == d + 1) else begin
                err_run++;
                $display("error %0t poll_bytes expected %0d got %0d", $time, d + 1, poll_bytes);
            end
        end else begin
            assert (ledr0 === 1'b0) else begin
                err_run++;
                $display("error %0t LEDR0 expected 0 got %b", $time, ledr0);
            end
            assert (poll_bytes == int'(poll_limit)) else begin
                err_run++;
                $display("error %0t poll_bytes expected %0d got %0d", $time,
                         int'(poll_limit), poll_bytes);
            end
        end
        assert (cmd_match === 1'b1) else begin
            err_run++;
            $display("card model did not receive a valid CMD0");
        end
        while (rx_chars.size() - text_base < exp.len()) @(posedge clk);
        for (int i = 0; i < exp.len(); i++) begin
            assert (rx_chars[text_base + i] == exp[i]) else begin
                err_run++;
                $display("error %0t UART_TXD char %0d expected %h got %h", $time, i,
                         exp[i], rx_chars[text_base + i]);
            end
        end
    endtask

    initial begin
        int d;
        int total;
        key_pulse   <= 1'b1;
        silent      <= 1'b0;
        delay_bytes <= 3'd0;
        lfsr      = 8'd68;
        text_base = 0;
        err_reset = 0;
        err_spi   = 0;
        err_prop  = 0;
        err_run   = 0;
        err_uart  = 0;
        wait (gen_rst_n === 1'b0);
        wait (gen_rst_n === 1'b1);

        // responding card
        start_run(1'b0, d);
        finish_run(1'b1, d);

        // silent card runs into the poll limit
        start_run(1'b1, d);
        finish_run(1'b0, d);

        // reset in the middle of CMD0, then a full run
        start_run(1'b0, d);
        while (low_bits < 16) @(posedge clk);
        start_run(1'b0, d);
        finish_run(1'b1, d);

        repeat (10) @(posedge clk);
        total = err_reset + err_spi + err_prop + err_run + err_uart;
        $display("errors: reset %0d spi %0d property %0d run %0d uart %0d total %0d",
                 err_reset, err_spi, err_prop, err_run, err_uart, total);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog sized from the worst-case run length
    initial begin
        repeat ((num_runs + 1) * run_cycles) @(posedge clk);
        $display("timeout: the test runs did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* compile.f */
hw/sd_spi_pkg.sv
hw/spi_clock_divider.sv
hw/spi_byte_shifter.sv
hw/sd_cmd0_sequencer.sv
hw/status_message_tx.sv
hw/sd_probe_top.sv
dv/tb_clock_gen.sv
dv/sd_card_model.sv
dv/tb_sd_probe.sv

/* run_sim.sh */
#!/bin/sh
# build and run the SD probe testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_sd_probe -f compile.f -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
if echo "$out" | grep -q "STATUS: PASS"; then
    exit 0
fi
exit 1
